// File: test/execute_testdata.txt
# name instr res_rd res_data res_mem_addr res_mem_data res_mem_kind load_value drop
# fields after the name are hex; drop is 1 for a word that must give no result
lui_x1       123450b7 01 00000000 12345000 00000000 0 00000000 0
lw_x2        10002103 02 00000000 00000100 00000000 5 fffffff9 0
lw_x3        10402183 03 00000000 00000104 00000000 5 00000003 0
lw_x4_neg    ffc02203 04 00000000 fffffffc 00000000 5 80000000 0
lw_x5        10802283 05 00000000 00000108 00000000 5 ffffffff 0
add          00208333 06 12344ff9 00000000 00000000 0 00000000 0
sub          403083b3 07 12344ffd 00000000 00000000 0 00000000 0
slt          00312433 08 00000001 00000000 00000000 0 00000000 0
sltu         003134b3 09 00000000 00000000 00000000 0 00000000 0
sll_mod32    00219533 0a 06000000 00000000 00000000 0 00000000 0
srl          003255b3 0b 10000000 00000000 00000000 0 00000000 0
sra          40325633 0c f0000000 00000000 00000000 0 00000000 0
xor          0050c6b3 0d edcbafff 00000000 00000000 0 00000000 0
or           0030e733 0e 12345003 00000000 00000000 0 00000000 0
and          003377b3 0f 00000001 00000000 00000000 0 00000000 0
mul_neg      02310833 10 ffffffeb 00000000 00000000 0 00000000 0
mulh_neg     023118b3 11 ffffffff 00000000 00000000 0 00000000 0
mulhsu_neg   02312933 12 ffffffff 00000000 00000000 0 00000000 0
mulhu        023139b3 13 00000002 00000000 00000000 0 00000000 0
mulh_min     02421a33 14 40000000 00000000 00000000 0 00000000 0
mulhsu_mix   02522ab3 15 80000000 00000000 00000000 0 00000000 0
mul_pos      02308b33 16 369cf000 00000000 00000000 0 00000000 0
div_mix      02314bb3 17 fffffffe 00000000 00000000 0 00000000 0
rem_mix      02316c33 18 ffffffff 00000000 00000000 0 00000000 0
divu         02315cb3 19 55555553 00000000 00000000 0 00000000 0
remu         02617d33 1a 0123a05b 00000000 00000000 0 00000000 0
div_zero     0200cdb3 1b ffffffff 00000000 00000000 0 00000000 0
rem_zero     02016e33 1c fffffff9 00000000 00000000 0 00000000 0
div_ovf      02524eb3 1d 80000000 00000000 00000000 0 00000000 0
rem_ovf      02526f33 1e 00000000 00000000 00000000 0 00000000 0
divu_zero    0202dfb3 1f ffffffff 00000000 00000000 0 00000000 0
chain_1      00330333 06 12344ffc 00000000 00000000 0 00000000 0
chain_2      00630333 06 24689ff8 00000000 00000000 0 00000000 0
chain_3      402303b3 07 24689fff 00000000 00000000 0 00000000 0
chain_4      0063c333 06 00000007 00000000 00000000 0 00000000 0
write_x0     00108033 00 2468a000 00000000 00000000 0 00000000 0
read_x0      00300433 08 00000003 00000000 00000000 0 00000000 0
lb           fff08483 09 00000000 12344fff 00000000 1 ffffff80 0
lbu          0051c503 0a 00000000 00000008 00000000 2 000000a5 0
lh           7fe01583 0b 00000000 000007fe 00000000 3 ffff8001 0
lhu          0024d603 0c 00000000 ffffff82 00000000 4 0000beef 0
sw           0030a423 00 00000000 12345008 00000003 8 00000000 0
sh           fec51f23 00 00000000 000000a3 0000beef 7 00000000 0
sb           00b58823 00 00000000 ffff8011 ffff8001 6 00000000 0
lui_x13      fffff6b7 0d 00000000 fffff000 00000000 0 00000000 0
add_lui      00d68733 0e ffffe000 00000000 00000000 0 00000000 0
ecall        00000073 00 00000000 00000000 00000000 0 00000000 1
csrrw        300110f3 00 00000000 00000000 00000000 0 00000000 1
after_drop   000087b3 0f 12345000 00000000 00000000 0 00000000 0
addi         00108093 00 00000000 00000000 00000000 0 00000000 1
ebreak       00100073 00 00000000 00000000 00000000 0 00000000 1
mul_last     02378833 10 369cf000 00000000 00000000 0 00000000 0

// File: list.f
source/exec_pkg.sv
source/register_file.sv
source/instr_decoder.sv
source/executor.sv
source/execute_core.sv
test/clock_gen.sv
test/execute_core_tb.sv

// File: Makefile
TOP = execute_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module $(TOP)

# pass only when the log holds the pass message
sim:
	verilator --binary --timing -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/execute_core_tb.sv
`timescale 1ns/10ps
module execute_core_tb
  import exec_pkg::*;
();
  localparam int          max_tests = 64;
  localparam logic [31:0] seed      = 32'h697f5583;

  logic      clk;
  logic      reset;
  logic      instr_valid;
  logic      instr_ready;
  word_t     instr;
  logic      res_valid;
  logic      res_ready;
  reg_addr_t res_rd;
  word_t     res_data;
  word_t     res_mem_addr;
  word_t     res_mem_data;
  mem_kind_t res_mem_kind;
  logic      wb_valid;
  reg_addr_t wb_rd;
  word_t     wb_data;

  string     test_name [max_tests];
  word_t     test_instr [max_tests];
  reg_addr_t exp_rd [max_tests];
  word_t     exp_data [max_tests];
  word_t     exp_addr [max_tests];
  word_t     exp_mem_data [max_tests];
  mem_kind_t exp_kind [max_tests];
  word_t     load_value [max_tests];
  logic      dropped [max_tests];

  int          num_tests;
  int          num_results;
  int          results_seen;
  int          next_test;
  int          errors;
  int          failed_tests;
  int          cycles;
  int          cycle_limit;
  logic        stray;
  logic [31:0] drive_rng;
  logic [31:0] mem_rng;

  clock_gen clocks (.clk, .reset);

  execute_core UUT (
    .clk, .reset,
    .instr_valid, .instr_ready, .instr,
    .res_valid, .res_ready, .res_rd, .res_data, .res_mem_addr, .res_mem_data, .res_mem_kind,
    .wb_valid, .wb_rd, .wb_data
  );

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input string test, input string field, input word_t expected,
                       input word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("error: %s %s expected %h actual %h", test, field, expected, actual);
    end
  endtask

  task automatic read_tests();
    int        fd;
    int        code;
    int        n;
    string     line;
    string     name;
    word_t     w_instr;
    reg_addr_t w_rd;
    word_t     w_data;
    word_t     w_addr;
    word_t     w_mem_data;
    mem_kind_t w_kind;
    word_t     w_load;
    logic      w_drop;
    fd = $fopen("test/execute_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test data file");
    end else begin
      while (!$feof(fd) && num_tests < max_tests) begin
        code = $fgets(line, fd);
        // skip comments and blank lines
        if (code > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, w_instr, w_rd, w_data,
                      w_addr, w_mem_data, w_kind, w_load, w_drop);
          if (n == 9) begin
            test_name[num_tests] = name;
            test_instr[num_tests] = w_instr;
            exp_rd[num_tests] = w_rd;
            exp_data[num_tests] = w_data;
            exp_addr[num_tests] = w_addr;
            exp_mem_data[num_tests] = w_mem_data;
            exp_kind[num_tests] = w_kind;
            load_value[num_tests] = w_load;
            dropped[num_tests] = w_drop;
            if (!w_drop) begin
              num_results++;
            end
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: failed", name);
    end
  endtask

  // dropped words ahead of the next expected result
  task automatic report_dropped();
    while (next_test < num_tests && dropped[next_test]) begin
      $display("test %s: ok, no result", test_name[next_test]);
      next_test++;
    end
  endtask

  task automatic drive_instructions();
    for (int i = 0; i < num_tests; i++) begin
      drive_rng = xorshift(drive_rng);
      repeat (drive_rng[1:0]) step();
      instr = test_instr[i];
      instr_valid = 1'b1;
      @(negedge clk);
      while (!instr_ready) begin
        @(negedge clk);
      end
      step();
      instr_valid = 1'b0;
    end
  endtask

  // plays the memory stage, one result at a time
  task automatic serve_results();
    int        delay;
    int        errors_before;
    reg_addr_t rd;
    word_t     data;
    word_t     addr;
    word_t     mem_data;
    mem_kind_t kind;
    while (results_seen < num_results) begin
      step();
      mem_rng = xorshift(mem_rng);
      res_ready = mem_rng[1:0] != 2'b00;
      @(negedge clk);
      if (res_valid && res_ready) begin
        rd = res_rd;
        data = res_data;
        addr = res_mem_addr;
        mem_data = res_mem_data;
        kind = res_mem_kind;
        report_dropped();
        errors_before = errors;
        check(test_name[next_test], "rd", word_t'(exp_rd[next_test]), word_t'(rd));
        check(test_name[next_test], "data", exp_data[next_test], data);
        check(test_name[next_test], "mem_addr", exp_addr[next_test], addr);
        check(test_name[next_test], "mem_data", exp_mem_data[next_test], mem_data);
        check(test_name[next_test], "mem_kind", word_t'(exp_kind[next_test]), word_t'(kind));
        report_test(test_name[next_test], errors_before);
        delay = int'(mem_rng[6:4]) % 7;
        step();
        res_ready = 1'b0;
        repeat (delay) step();
        if (!(kind inside {mem_sb, mem_sh, mem_sw})) begin
          wb_rd = rd;
          if (kind inside {mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw}) begin
            wb_data = load_value[next_test];
          end else if (test_instr[next_test][6:0] == 7'b0110111) begin
            wb_data = addr;
          end else begin
            wb_data = data;
          end
          wb_valid = 1'b1;
          step();
          wb_valid = 1'b0;
        end
        results_seen++;
        next_test++;
      end
    end
  endtask

  initial begin
    instr_valid = 1'b0;
    instr = '0;
    res_ready = 1'b0;
    wb_valid = 1'b0;
    wb_rd = '0;
    wb_data = '0;
    num_tests = 0;
    num_results = 0;
    results_seen = 0;
    next_test = 0;
    errors = 0;
    failed_tests = 0;
    cycles = 0;
    stray = 1'b0;
    drive_rng = seed;
    // second stream from the same seed
    mem_rng = ~seed;
    read_tests();
    cycle_limit = 100 * num_tests + 200;
    wait (reset === 1'b0);
    step();
    fork
      drive_instructions();
      serve_results();
    join
    // nothing may come out after the last expected result
    repeat (30) begin
      @(negedge clk);
      if (res_valid) begin
        stray = 1'b1;
      end
    end
    while (next_test < num_tests) begin
      if (stray) begin
        $display("test %s: failed", test_name[next_test]);
        failed_tests++;
      end else begin
        $display("test %s: ok, no result", test_name[next_test]);
      end
      next_test++;
    end
    if (stray) begin
      errors++;
      $display("a result came out although no instruction was left to produce one");
    end
    $display("tests: %0d  failed: %0d  errors: %0d", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, only %0d of %0d results arrived",
               cycles, results_seen, num_results);
      $display("Done: errors found");
      $finish;
    end
  end

endmodule

// File: test/clock_gen.sv
`timescale 1ns/10ps
module clock_gen (
  output var logic clk,
  output var logic reset
);
  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// File: source/execute_core.sv
`timescale 1ns/10ps
module execute_core
  import exec_pkg::*;
(
  input  var logic      clk,
  input  var logic      reset,
  input  var logic      instr_valid,
  output var logic      instr_ready,
  input  var word_t     instr,
  output var logic      res_valid,
  input  var logic      res_ready,
  output var reg_addr_t res_rd,
  output var word_t     res_data,
  output var word_t     res_mem_addr,
  output var word_t     res_mem_data,
  output var mem_kind_t res_mem_kind,
  input  var logic      wb_valid,
  input  var reg_addr_t wb_rd,
  input  var word_t     wb_data
);
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_val;
  word_t     rs2_val;
  logic      rs1_pending;
  logic      rs2_pending;
  logic      issue_set;
  reg_addr_t issue_rd;

  // issue stream
  logic      dec_valid;
  logic      dec_ready;
  op_t       dec_op;
  reg_addr_t dec_rd;
  word_t     dec_rs1_val;
  word_t     dec_rs2_val;
  word_t     dec_mem_addr;
  mem_kind_t dec_mem_kind;

  register_file regs (
    .clk, .reset,
    .rs1_addr, .rs2_addr, .rs1_val, .rs2_val, .rs1_pending, .rs2_pending,
    .issue_set, .issue_rd,
    .wb_valid, .wb_rd, .wb_data
  );

  instr_decoder decoder (
    .clk, .reset,
    .instr_valid, .instr, .instr_ready,
    .rs1_addr, .rs2_addr, .rs1_val, .rs2_val, .rs1_pending, .rs2_pending,
    .issue_set, .issue_rd,
    .dec_valid, .dec_op, .dec_rd, .dec_rs1_val, .dec_rs2_val, .dec_mem_addr, .dec_mem_kind,
    .dec_ready
  );

  executor exec (
    .clk, .reset,
    .dec_valid, .dec_op, .dec_rd, .dec_rs1_val, .dec_rs2_val, .dec_mem_addr, .dec_mem_kind,
    .dec_ready,
    .res_valid, .res_rd, .res_data, .res_mem_addr, .res_mem_data, .res_mem_kind,
    .res_ready
  );

endmodule

// File: source/executor.sv
`timescale 1ns/10ps
module executor
  import exec_pkg::*;
(
  input  var logic      clk,
  input  var logic      reset,
  input  var logic      dec_valid,
  input  var op_t       dec_op,
  input  var reg_addr_t dec_rd,
  input  var word_t     dec_rs1_val,
  input  var word_t     dec_rs2_val,
  input  var word_t     dec_mem_addr,
  input  var mem_kind_t dec_mem_kind,
  output var logic      dec_ready,
  output var logic      res_valid,
  output var reg_addr_t res_rd,
  output var word_t     res_data,
  output var word_t     res_mem_addr,
  output var word_t     res_mem_data,
  output var mem_kind_t res_mem_kind,
  input  var logic      res_ready
);
  typedef enum logic [1:0] {
    st_idle,
    st_multiply,
    st_divide,
    st_hold
  } state_t;

  localparam logic [6:0] mul_lo_steps = 7'd32;
  localparam logic [6:0] mul_hi_steps = 7'd64;
  localparam logic [6:0] div_steps    = 7'd33;

  state_t      state;
  logic        started;
  logic        issue;
  word_t       alu_result;
  logic [4:0]  shamt;
  logic        mul_x_sext;
  logic        mul_y_sext;
  logic        div_signed;
  logic        rs1_neg;
  logic        rs2_neg;
  word_t       rs1_mag;
  word_t       rs2_mag;
  op_t         op_q;
  logic        rs1_neg_q;
  logic        rs2_neg_q;
  logic        rs2_zero_q;
  logic [6:0]  count;
  logic [63:0] md_x;
  logic [63:0] md_y;
  logic [63:0] md_acc;

  assign dec_ready = started && state == st_idle && (!res_valid || res_ready);
  assign issue     = dec_valid && dec_ready;

  assign shamt = dec_rs2_val[4:0];

  // loads, stores and lui fall to the default, leaving zero
  always_comb begin
    case (dec_op)
      op_add:  alu_result = dec_rs1_val + dec_rs2_val;
      op_sub:  alu_result = dec_rs1_val - dec_rs2_val;
      op_sll:  alu_result = dec_rs1_val << shamt;
      op_slt:  alu_result = {31'b0, $signed(dec_rs1_val) < $signed(dec_rs2_val)};
      op_sltu: alu_result = {31'b0, dec_rs1_val < dec_rs2_val};
      op_xor:  alu_result = dec_rs1_val ^ dec_rs2_val;
      op_srl:  alu_result = dec_rs1_val >> shamt;
      op_sra:  alu_result = $signed(dec_rs1_val) >>> shamt;
      op_or:   alu_result = dec_rs1_val | dec_rs2_val;
      op_and:  alu_result = dec_rs1_val & dec_rs2_val;
      default: alu_result = '0;
    endcase
  end

  // operand extension for the 64 bit multiply
  assign mul_x_sext = (dec_op == op_mulh || dec_op == op_mulhsu) && dec_rs1_val[31];
  assign mul_y_sext = dec_op == op_mulh && dec_rs2_val[31];

  // divide works on magnitudes
  assign div_signed = dec_op == op_div || dec_op == op_rem;
  assign rs1_neg    = div_signed && dec_rs1_val[31];
  assign rs2_neg    = div_signed && dec_rs2_val[31];
  assign rs1_mag    = rs1_neg ? -dec_rs1_val : dec_rs1_val;
  assign rs2_mag    = rs2_neg ? -dec_rs2_val : dec_rs2_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      started <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      case (state)
        st_idle: begin
          if (res_valid && res_ready) begin
            res_valid <= 1'b0;
          end
          if (issue) begin
            op_q <= dec_op;
            res_rd <= dec_rd;
            res_data <= alu_result;
            res_mem_addr <= dec_mem_addr;
            res_mem_data <= (dec_op == op_store) ? dec_rs2_val : '0;
            res_mem_kind <= dec_mem_kind;
            case (dec_op)
              op_mul, op_mulh, op_mulhsu, op_mulhu: begin
                state <= st_multiply;
                count <= (dec_op == op_mul) ? mul_lo_steps : mul_hi_steps;
                md_acc <= '0;
                md_x <= {{32{mul_x_sext}}, dec_rs1_val};
                md_y <= {{32{mul_y_sext}}, dec_rs2_val};
              end
              op_div, op_divu, op_rem, op_remu: begin
                state <= st_divide;
                count <= div_steps;
                md_acc <= '0;
                md_x <= {32'b0, rs1_mag};
                md_y <= {rs2_mag, 32'b0};
                rs1_neg_q <= rs1_neg;
                rs2_neg_q <= rs2_neg;
                rs2_zero_q <= dec_rs2_val == '0;
              end
              default: res_valid <= 1'b1;
            endcase
          end else if (res_valid && !res_ready) begin
            state <= st_hold;
          end
        end

        st_multiply: begin
          if (count != '0) begin
            if (md_y[0]) begin
              md_acc <= md_acc + md_x;
            end
            md_x <= md_x << 1;
            md_y <= md_y >> 1;
            count <= count - 7'd1;
          end else begin
            res_data <= (op_q == op_mul) ? md_acc[31:0] : md_acc[63:32];
            res_valid <= 1'b1;
            state <= st_idle;
          end
        end

        st_divide: begin
          if (count != '0) begin
            // restoring step, one quotient bit
            if (md_x >= md_y) begin
              md_x <= md_x - md_y;
              md_acc <= {md_acc[62:0], 1'b1};
            end else begin
              md_acc <= {md_acc[62:0], 1'b0};
            end
            md_y <= md_y >> 1;
            count <= count - 7'd1;
          end else begin
            // divide by zero keeps the all-ones quotient
            if (op_q == op_div || op_q == op_divu) begin
              res_data <= ((rs1_neg_q ^ rs2_neg_q) && !rs2_zero_q) ? -md_acc[31:0]
                                                                   : md_acc[31:0];
            end else begin
              res_data <= rs1_neg_q ? -md_x[31:0] : md_x[31:0];
            end
            res_valid <= 1'b1;
            state <= st_idle;
          end
        end

        st_hold: begin
          if (res_ready) begin
            res_valid <= 1'b0;
            state <= st_idle;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/10ps
module instr_decoder
  import exec_pkg::*;
(
  input  var logic      clk,
  input  var logic      reset,
  input  var logic      instr_valid,
  input  var word_t     instr,
  output var logic      instr_ready,
  output var reg_addr_t rs1_addr,
  output var reg_addr_t rs2_addr,
  input  var word_t     rs1_val,
  input  var word_t     rs2_val,
  input  var logic      rs1_pending,
  input  var logic      rs2_pending,
  output var logic      issue_set,
  output var reg_addr_t issue_rd,
  output var logic      dec_valid,
  output var op_t       dec_op,
  output var reg_addr_t dec_rd,
  output var word_t     dec_rs1_val,
  output var word_t     dec_rs2_val,
  output var word_t     dec_mem_addr,
  output var mem_kind_t dec_mem_kind,
  input  var logic      dec_ready
);
  localparam logic [6:0] opc_op    = 7'b0110011;
  localparam logic [6:0] opc_lui   = 7'b0110111;
  localparam logic [6:0] opc_load  = 7'b0000011;
  localparam logic [6:0] opc_store = 7'b0100011;

  logic       started;
  logic       slot_valid;
  word_t      slot_instr;
  logic       supported;
  logic       use_rs1;
  logic       use_rs2;
  logic       stalled;
  logic       issue;
  logic       slot_free;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;

  assign opcode   = slot_instr[6:0];
  assign funct3   = slot_instr[14:12];
  assign funct7   = slot_instr[31:25];
  assign rs1_addr = slot_instr[19:15];
  assign rs2_addr = slot_instr[24:20];
  assign imm_i    = {{20{slot_instr[31]}}, slot_instr[31:20]};
  assign imm_s    = {{20{slot_instr[31]}}, slot_instr[31:25], slot_instr[11:7]};

  always_comb begin
    supported    = 1'b0;
    use_rs1      = 1'b0;
    use_rs2      = 1'b0;
    dec_op       = op_add;
    dec_rd       = slot_instr[11:7];
    dec_mem_addr = '0;
    dec_mem_kind = mem_none;
    case (opcode)
      opc_op: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        if (funct7 == 7'b0000001) begin
          supported = 1'b1;
          case (funct3)
            3'b000:  dec_op = op_mul;
            3'b001:  dec_op = op_mulh;
            3'b010:  dec_op = op_mulhsu;
            3'b011:  dec_op = op_mulhu;
            3'b100:  dec_op = op_div;
            3'b101:  dec_op = op_divu;
            3'b110:  dec_op = op_rem;
            default: dec_op = op_remu;
          endcase
        end else if (funct7 == 7'b0000000) begin
          supported = 1'b1;
          case (funct3)
            3'b000:  dec_op = op_add;
            3'b001:  dec_op = op_sll;
            3'b010:  dec_op = op_slt;
            3'b011:  dec_op = op_sltu;
            3'b100:  dec_op = op_xor;
            3'b101:  dec_op = op_srl;
            3'b110:  dec_op = op_or;
            default: dec_op = op_and;
          endcase
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          supported = 1'b1;
          dec_op = funct3[2] ? op_sra : op_sub;
        end
      end
      opc_lui: begin
        supported    = 1'b1;
        dec_op       = op_lui;
        dec_mem_addr = {slot_instr[31:12], 12'b0};
      end
      opc_load: begin
        use_rs1      = 1'b1;
        dec_op       = op_load;
        dec_mem_addr = rs1_val + imm_i;
        supported    = 1'b1;
        case (funct3)
          3'b000:  dec_mem_kind = mem_lb;
          3'b001:  dec_mem_kind = mem_lh;
          3'b010:  dec_mem_kind = mem_lw;
          3'b100:  dec_mem_kind = mem_lbu;
          3'b101:  dec_mem_kind = mem_lhu;
          default: supported = 1'b0;
        endcase
      end
      opc_store: begin
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        dec_op       = op_store;
        dec_rd       = '0;
        dec_mem_addr = rs1_val + imm_s;
        supported    = 1'b1;
        case (funct3)
          3'b000:  dec_mem_kind = mem_sb;
          3'b001:  dec_mem_kind = mem_sh;
          3'b010:  dec_mem_kind = mem_sw;
          default: supported = 1'b0;
        endcase
      end
      default: supported = 1'b0;
    endcase
  end

  // only the sources this format reads
  assign stalled     = (use_rs1 && rs1_pending) || (use_rs2 && rs2_pending);
  assign dec_valid   = slot_valid && supported && !stalled;
  assign issue       = dec_valid && dec_ready;
  // unsupported words leave the slot without issue
  assign slot_free   = !slot_valid || issue || !supported;
  assign instr_ready = started && slot_free;
  assign dec_rs1_val = rs1_val;
  assign dec_rs2_val = rs2_val;
  assign issue_set   = issue && dec_rd != '0;
  assign issue_rd    = dec_rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      slot_valid <= 1'b0;
    end else begin
      started <= 1'b1;
      if (instr_valid && instr_ready) begin
        slot_valid <= 1'b1;
      end else if (slot_free) begin
        slot_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid && instr_ready) begin
      slot_instr <= instr;
    end
  end

endmodule

// File: source/register_file.sv
`timescale 1ns/10ps
module register_file
  import exec_pkg::*;
(
  input  var logic      clk,
  input  var logic      reset,
  input  var reg_addr_t rs1_addr,
  input  var reg_addr_t rs2_addr,
  output var word_t     rs1_val,
  output var word_t     rs2_val,
  output var logic      rs1_pending,
  output var logic      rs2_pending,
  input  var logic      issue_set,
  input  var reg_addr_t issue_rd,
  input  var logic      wb_valid,
  input  var reg_addr_t wb_rd,
  input  var word_t     wb_data
);
  word_t      regs [32];
  // writes in flight per register, nonzero means pending
  logic [1:0] pending_count [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        pending_count[i] <= '0;
      end
    end else begin
      if (wb_valid && wb_rd != '0) begin
        regs[wb_rd] <= wb_data;
      end
      // x0 never goes pending
      for (int i = 1; i < 32; i++) begin
        if (issue_set && issue_rd == reg_addr_t'(i)) begin
          if (!(wb_valid && wb_rd == reg_addr_t'(i))) begin
            pending_count[i] <= pending_count[i] + 2'd1;
          end
        end else if (wb_valid && wb_rd == reg_addr_t'(i) && pending_count[i] != '0) begin
          pending_count[i] <= pending_count[i] - 2'd1;
        end
      end
    end
  end

  assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];
  assign rs1_pending = pending_count[rs1_addr] != '0;
  assign rs2_pending = pending_count[rs2_addr] != '0;

endmodule

// File: source/exec_pkg.sv
package exec_pkg;

  // data and register widths of RV32
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // operation issued to the executor
  typedef logic [4:0]  op_t;

  // memory access forwarded to the memory stage
  typedef logic [3:0]  mem_kind_t;

  localparam op_t op_add    = 5'd0;
  localparam op_t op_sub    = 5'd1;
  localparam op_t op_sll    = 5'd2;
  localparam op_t op_slt    = 5'd3;
  localparam op_t op_sltu   = 5'd4;
  localparam op_t op_xor    = 5'd5;
  localparam op_t op_srl    = 5'd6;
  localparam op_t op_sra    = 5'd7;
  localparam op_t op_or     = 5'd8;
  localparam op_t op_and    = 5'd9;
  localparam op_t op_mul    = 5'd10;
  localparam op_t op_mulh   = 5'd11;
  localparam op_t op_mulhsu = 5'd12;
  localparam op_t op_mulhu  = 5'd13;
  localparam op_t op_div    = 5'd14;
  localparam op_t op_divu   = 5'd15;
  localparam op_t op_rem    = 5'd16;
  localparam op_t op_remu   = 5'd17;
  localparam op_t op_lui    = 5'd18;
  localparam op_t op_load   = 5'd19;
  localparam op_t op_store  = 5'd20;

  // nine kinds, so four bits
  localparam mem_kind_t mem_none = 4'd0;
  localparam mem_kind_t mem_lb   = 4'd1;
  localparam mem_kind_t mem_lbu  = 4'd2;
  localparam mem_kind_t mem_lh   = 4'd3;
  localparam mem_kind_t mem_lhu  = 4'd4;
  localparam mem_kind_t mem_lw   = 4'd5;
  localparam mem_kind_t mem_sb   = 4'd6;
  localparam mem_kind_t mem_sh   = 4'd7;
  localparam mem_kind_t mem_sw   = 4'd8;

endpackage
